// File: Makefile
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = wb_subsys_tb
FILELIST = wb_subsys.f
OBJ_DIR  = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/wb_tb_table.svh
// Wishbone subsystem test table
// Each row holds we, address, write data, sel, expected read data,
// expected err, expected status_o and the test name

task automatic load_table();
    // RAM word 1 after the two-lane write of pattern 3
    wb_data_t merged;
    merged = {ram_pat[1][31:24], ram_pat[3][23:16], ram_pat[1][15:8], ram_pat[3][7:0]};

    // Reset values
    add_row(1'b0, 32'h1000_0000, 32'h0, 4'hF, 32'h0, 1'b0, 32'h0, "reset_scratch");
    add_row(1'b0, 32'h1000_0004, 32'h0, 4'hF, 32'h0, 1'b0, 32'h0, "reset_status");

    // RAM full words followed by partial lanes and aliasing
    add_row(1'b1, 32'h0000_0000, ram_pat[0], 4'hF, 32'h0, 1'b0, 32'h0, "ram_write_w0");
    add_row(1'b1, 32'h0000_0004, ram_pat[1], 4'hF, 32'h0, 1'b0, 32'h0, "ram_write_w1");
    add_row(1'b1, 32'h0000_03FC, ram_pat[2], 4'hF, 32'h0, 1'b0, 32'h0, "ram_write_top");
    add_row(1'b0, 32'h0000_0000, 32'h0, 4'hF, ram_pat[0], 1'b0, 32'h0, "ram_read_w0");
    add_row(1'b0, 32'h0000_0004, 32'h0, 4'hF, ram_pat[1], 1'b0, 32'h0, "ram_read_w1");
    add_row(1'b0, 32'h0000_03FC, 32'h0, 4'hF, ram_pat[2], 1'b0, 32'h0, "ram_read_top");
    add_row(1'b1, 32'h0000_0004, ram_pat[3], 4'h5, 32'h0, 1'b0, 32'h0, "ram_partial_write");
    add_row(1'b0, 32'h0000_0004, 32'h0, 4'hF, merged, 1'b0, 32'h0, "ram_partial_read");
    // 1 KiB higher lands on the same word
    add_row(1'b0, 32'h0000_0404, 32'h0, 4'hF, merged, 1'b0, 32'h0, "ram_alias_read");

    // Scratch and status set and clear
    add_row(1'b1, 32'h1000_0000, 32'hA5C3_0F96, 4'hF, 32'h0, 1'b0, 32'h0, "scratch_write");
    add_row(1'b0, 32'h1000_0000, 32'h0, 4'hF, 32'hA5C3_0F96, 1'b0, 32'h0, "scratch_read");
    add_row(1'b1, 32'h1000_0004, 32'h0000_00F0, 4'hF, 32'h0, 1'b0, 32'h0000_00F0, "status_set");
    add_row(1'b1, 32'h1000_0004, 32'h8000_0003, 4'hF, 32'h0, 1'b0, 32'h8000_00F3,
            "status_set_more");
    add_row(1'b1, 32'h1000_0008, 32'h0000_0030, 4'hF, 32'h0, 1'b0, 32'h8000_00C3,
            "status_clear");
    add_row(1'b0, 32'h1000_0008, 32'h0, 4'hF, 32'h8000_00C3, 1'b0, 32'h8000_00C3,
            "status_read_clr");

    // Read-only ID word
    add_row(1'b0, 32'h1000_000C, 32'h0, 4'hF, `REGS_ID, 1'b0, 32'h8000_00C3, "id_read");
    add_row(1'b1, 32'h1000_000C, 32'hFFFF_FFFF, 4'hF, 32'h0, 1'b1, 32'h8000_00C3,
            "id_write_err");
    add_row(1'b0, 32'h1000_000C, 32'h0, 4'hF, `REGS_ID, 1'b0, 32'h8000_00C3, "id_after_write");

    // Unmapped range where nothing may reach a slave
    add_row(1'b1, 32'h2000_0000, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b1, 32'h8000_00C3,
            "unmapped_write");
    add_row(1'b0, 32'h2000_0000, 32'h0, 4'hF, 32'h0, 1'b1, 32'h8000_00C3, "unmapped_read");
    add_row(1'b0, 32'h0000_0000, 32'h0, 4'hF, ram_pat[0], 1'b0, 32'h8000_00C3,
            "ram_after_unmapped");
    add_row(1'b0, 32'h1000_0000, 32'h0, 4'hF, 32'hA5C3_0F96, 1'b0, 32'h8000_00C3,
            "scratch_after_unmapped");
endtask

// File: bench/wb_subsys_tb.sv
// Wishbone subsystem testbench
`include "wb_subsys_settings.svh"

module wb_subsys_tb import wb_subsys_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    // Cycles a single access may wait for ack or err
    localparam int RESP_WAIT    = 4;

    // One table row
    typedef struct packed {
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
        wb_data_t exp_dat;
        logic     exp_err;
        wb_data_t exp_status;
    } row_t;

    logic     clk;
    logic     rst_n;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_sel_t  wb_sel;
    logic     wb_we;
    logic     wb_cyc;
    logic     wb_stb;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     wb_err;
    wb_data_t status;

    row_t     rows[$];
    string    names[$];
    // RAM data patterns drawn before the table is built
    wb_data_t ram_pat [4];

    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycles      = 0;
    int cycle_limit = 0;

    wb_subsys i_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .status_o (status)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           input wb_sel_t sel, input wb_data_t exp_dat, input logic exp_err,
                           input wb_data_t exp_status, input string name);
        row_t r;
        r.we         = we;
        r.adr        = adr;
        r.dat        = dat;
        r.sel        = sel;
        r.exp_dat    = exp_dat;
        r.exp_err    = exp_err;
        r.exp_status = exp_status;
        rows.push_back(r);
        names.push_back(name);
    endtask

    `include "wb_tb_table.svh"

    // Compare and report a wrong value
    task automatic check_value(input string signal, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", signal, expected, actual);
            test_errors++;
        end
    endtask

    // One classic cycle held until ack or err
    task automatic bus_access(input row_t r, output wb_data_t rdata, output logic got_ack,
                              output logic got_err, output wb_data_t got_status,
                              output logic responded);
        int waited;
        waited     = 0;
        rdata      = '0;
        got_ack    = 1'b0;
        got_err    = 1'b0;
        got_status = '0;
        responded  = 1'b0;
        @(posedge clk);
        #1;
        wb_adr   = r.adr;
        wb_dat_w = r.dat;
        wb_sel   = r.sel;
        wb_we    = r.we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        // Responses are sampled mid-cycle where they are settled
        while (!responded && waited < RESP_WAIT) begin
            @(negedge clk);
            if (wb_ack || wb_err) begin
                responded  = 1'b1;
                got_ack    = wb_ack;
                got_err    = wb_err;
                rdata      = wb_dat_r;
                got_status = status;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Run limit
    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        integer   seed;
        wb_data_t rdata;
        wb_data_t got_status;
        logic     got_ack;
        logic     got_err;
        logic     responded;

        rst_n    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        wb_we    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;

        seed = 32'h1f45ffed;
        for (int i = 0; i < 4; i++) begin
            ram_pat[i] = $random(seed);
        end
        load_table();
        cycle_limit = RESET_CYCLES + rows.size() * 8 + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (rows[i]) begin
            test_errors = 0;
            bus_access(rows[i], rdata, got_ack, got_err, got_status, responded);
            if (!responded) begin
                $display("ERROR: %s got neither ack nor err", names[i]);
                test_errors++;
            end else begin
                if (got_ack && got_err) begin
                    $display("ERROR: %s saw ack and err high together", names[i]);
                    test_errors++;
                end
                check_value("wb_err_o", 32'(rows[i].exp_err), 32'(got_err));
                check_value("wb_ack_o", 32'(!rows[i].exp_err), 32'(got_ack));
                // Read data only matters for a good read
                if (!rows[i].we && !rows[i].exp_err) begin
                    check_value("wb_dat_o", rows[i].exp_dat, rdata);
                end
                check_value("status_o", rows[i].exp_status, got_status);
            end
            if (test_errors == 0) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("%s: %s", names[i], (test_errors == 0) ? "pass" : "fail");
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/wb_decode.sv
// Wishbone address decoder
`include "wb_subsys_settings.svh"

module wb_decode import wb_subsys_pkg::*; (
    // Request from the external master
    wb_if.slave  m_bus,
    // RAM side
    wb_if.master ram_bus,
    // Register block side
    wb_if.master regs_bus
);

    // Range hit per slave
    logic ram_sel;
    logic regs_sel;
    // Set when the hits are not exactly one-hot
    logic bus_error;
    // Active request on the master side
    logic m_req;

    // Response of the selected slave
    wb_data_t sel_dat;
    logic     sel_ack;
    logic     sel_err;

    // Compare the top address bits against each range
    assign ram_sel  = m_bus.adr[`WB_ADDR_WIDTH-1 -: `RAM_MATCH_WIDTH] == `RAM_MATCH;
    assign regs_sel = m_bus.adr[`WB_ADDR_WIDTH-1 -: `REGS_MATCH_WIDTH] == `REGS_MATCH;

    // No hit or two hits
    assign bus_error = ~(ram_sel ^ regs_sel);
    assign m_req     = m_bus.cyc & m_bus.stb;

    // Address, data, lanes and direction go to both slaves
    assign ram_bus.adr   = m_bus.adr;
    assign ram_bus.dat_w = m_bus.dat_w;
    assign ram_bus.sel   = m_bus.sel;
    assign ram_bus.we    = m_bus.we;

    assign regs_bus.adr   = m_bus.adr;
    assign regs_bus.dat_w = m_bus.dat_w;
    assign regs_bus.sel   = m_bus.sel;
    assign regs_bus.we    = m_bus.we;

    // Cycle and strobe only reach the selected slave
    // Nothing is forwarded on a decode error, so no slave sees side effects
    assign ram_bus.cyc  = m_bus.cyc & ram_sel & ~bus_error;
    assign ram_bus.stb  = m_bus.stb & ram_sel & ~bus_error;
    assign regs_bus.cyc = m_bus.cyc & regs_sel & ~bus_error;
    assign regs_bus.stb = m_bus.stb & regs_sel & ~bus_error;

    // Pick the response of the selected slave
    always_comb begin
        sel_dat = '0;
        sel_ack = 1'b0;
        sel_err = 1'b0;
        if (ram_sel) begin
            sel_dat = ram_bus.dat_r;
            sel_ack = ram_bus.ack;
            sel_err = ram_bus.err;
        end else if (regs_sel) begin
            sel_dat = regs_bus.dat_r;
            sel_ack = regs_bus.ack;
            sel_err = regs_bus.err;
        end
    end

    // Back to the master
    assign m_bus.dat_r = sel_dat;
    assign m_bus.ack   = sel_ack & ~bus_error;
    // Unmapped request answered in the same cycle as its strobe
    assign m_bus.err   = (sel_err & ~bus_error) | (bus_error & m_req);

endmodule

// File: hdl/wb_if.sv
// Wishbone classic bus
interface wb_if import wb_subsys_pkg::*; ();

    // Request side, driven by the master
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_sel_t  sel;
    logic     we;
    logic     cyc;
    logic     stb;

    // Response side, driven by the slave
    wb_data_t dat_r;
    logic     ack;
    logic     err;

    // Bus master view
    modport master (
        output adr, dat_w, sel, we, cyc, stb,
        input  dat_r, ack, err
    );

    // Bus slave view
    modport slave (
        input  adr, dat_w, sel, we, cyc, stb,
        output dat_r, ack, err
    );

endinterface

// File: hdl/wb_ram.sv
// Wishbone RAM slave
`include "wb_subsys_settings.svh"

module wb_ram import wb_subsys_pkg::*; (
    input  logic clk_i,
    input  logic rst_n_i,
    // Slave port towards the decoder
    wb_if.slave  bus
);

    // Word index width above the byte offset
    localparam int RAM_AW = $clog2(`RAM_WORDS);
    // Number of byte lanes
    localparam int LANES  = `WB_DATA_WIDTH / 8;

    // Word storage
    wb_data_t mem [`RAM_WORDS];

    logic [RAM_AW-1:0] idx;
    // New request held off while the ack is out
    logic              req;
    logic              ack_q;
    wb_data_t          rdata_q;

    // Address bits 9 to 2 pick the word and higher bits alias
    assign idx = bus.adr[RAM_AW+1:2];
    assign req = bus.cyc & bus.stb & ~ack_q;

    // One cycle ack that never comes twice in a row
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Byte lane writes and registered read
    always_ff @(posedge clk_i) begin
        if (req) begin
            // Read data lines up with the ack
            rdata_q <= mem[idx];
            if (bus.we) begin
                for (int b = 0; b < LANES; b++) begin
                    // Untouched lanes keep their old byte
                    if (bus.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;
    // Every RAM access succeeds
    assign bus.err   = 1'b0;

endmodule

// File: hdl/wb_regs.sv
// Wishbone control registers
`include "wb_subsys_settings.svh"

module wb_regs import wb_subsys_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Slave port towards the decoder
    wb_if.slave      bus,
    // Current status bits
    output wb_data_t status_o
);

    regs_offset_e offset;
    // Byte select expanded to a bit mask
    wb_data_t     wmask;
    // Masked write data
    wb_data_t     wdata;
    logic         req;
    // Write to the read-only ID word
    logic         id_write;

    wb_data_t scratch;
    wb_data_t status;
    logic     ack_q;
    logic     err_q;
    wb_data_t rdata_d;
    wb_data_t rdata_q;

    assign offset   = regs_offset_e'(bus.adr[3:2]);
    // Hold off while a response is out
    assign req      = bus.cyc & bus.stb & ~(ack_q | err_q);
    assign id_write = bus.we & (offset == REG_ID);

    always_comb begin
        for (int b = 0; b < `WB_DATA_WIDTH / 8; b++) begin
            wmask[8*b +: 8] = {8{bus.sel[b]}};
        end
    end
    assign wdata = bus.dat_w & wmask;

    // Both status offsets read the same word
    always_comb begin
        case (offset)
            REG_SCRATCH: rdata_d = scratch;
            REG_ID:      rdata_d = `REGS_ID;
            default:     rdata_d = status;
        endcase
    end

    // Response flags and register updates
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            scratch <= '0;
            status  <= '0;
        end else begin
            // err takes the place of ack for an ID write
            ack_q <= req & ~id_write;
            err_q <= req & id_write;
            if (req && bus.we) begin
                case (offset)
                    REG_SCRATCH:    scratch <= (scratch & ~wmask) | wdata;
                    REG_STATUS_SET: status  <= status | wdata;
                    REG_STATUS_CLR: status  <= status & ~wdata;
                    default:        ;
                endcase
            end
        end
    end

    // Read data captured with the response
    always_ff @(posedge clk_i) begin
        if (req) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign status_o  = status;

endmodule

// File: hdl/wb_subsys.sv
// Wishbone subsystem top
module wb_subsys import wb_subsys_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Master request
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    input  wb_sel_t  wb_sel_i,
    input  logic     wb_we_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,

    // Master response
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    output logic     wb_err_o,

    // Status bits from the register block
    output wb_data_t status_o
);

    // Decoder input side
    wb_if m_bus ();
    // Decoder output side with one bus per slave
    wb_if ram_bus ();
    wb_if regs_bus ();

    // External master onto the internal bus
    assign m_bus.adr   = wb_adr_i;
    assign m_bus.dat_w = wb_dat_i;
    assign m_bus.sel   = wb_sel_i;
    assign m_bus.we    = wb_we_i;
    assign m_bus.cyc   = wb_cyc_i;
    assign m_bus.stb   = wb_stb_i;

    assign wb_dat_o = m_bus.dat_r;
    assign wb_ack_o = m_bus.ack;
    assign wb_err_o = m_bus.err;

    // Address decode and response combine
    wb_decode i_decode (
        .m_bus    (m_bus.slave),
        .ram_bus  (ram_bus.master),
        .regs_bus (regs_bus.master)
    );

    // On-chip RAM
    wb_ram i_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (ram_bus.slave)
    );

    // Control registers
    wb_regs i_regs (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .bus      (regs_bus.slave),
        .status_o (status_o)
    );

endmodule

// File: hdl/wb_subsys_pkg.sv
// Wishbone subsystem types
`include "wb_subsys_settings.svh"

package wb_subsys_pkg;

    // Bus words
    typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

    // One select bit per data byte
    typedef logic [`WB_DATA_WIDTH/8-1:0] wb_sel_t;

    // Register word offset, address bits 3 to 2
    typedef enum logic [1:0] {
        // Plain read and write
        REG_SCRATCH    = 2'd0,
        // Reads status, write ORs bits in
        REG_STATUS_SET = 2'd1,
        // Reads status, write clears bits
        REG_STATUS_CLR = 2'd2,
        // Read only identification word
        REG_ID         = 2'd3
    } regs_offset_e;

endpackage

// File: hdl/wb_subsys_settings.svh
// Wishbone subsystem settings
`ifndef WB_SUBSYS_SETTINGS_SVH
`define WB_SUBSYS_SETTINGS_SVH

// Bus widths in bits, data width in whole bytes
`define WB_ADDR_WIDTH 32
`define WB_DATA_WIDTH 32

// RAM range 0x0000_0000 to 0x0FFF_FFFF
`define RAM_MATCH_WIDTH 4
`define RAM_MATCH 4'h0

// Register block range 0x1000_0000 to 0x10FF_FFFF
`define REGS_MATCH_WIDTH 8
`define REGS_MATCH 8'h10

// RAM depth in data words
`define RAM_WORDS 256

// Identification word of the register block
`define REGS_ID 32'h5742_0103

`endif

// File: wb_subsys.f
+incdir+hdl
+incdir+bench
hdl/wb_subsys_pkg.sv
hdl/wb_if.sv
hdl/wb_decode.sv
hdl/wb_ram.sv
hdl/wb_regs.sv
hdl/wb_subsys.sv
bench/wb_subsys_tb.sv
